/* rtl/alu.sv */
`timescale 1ns/1ps

module alu import tscPkg::*; (
    input  aluOpE                aluOperation,
    input  logic [WordWidth-1:0] opA,
    input  logic [WordWidth-1:0] opB,
    input  opcodeE               opcode,
    output logic [WordWidth-1:0] result,
    output logic                 branchTaken
);

    logic isZero;
    logic isNegative;

    always_comb begin
        case (aluOperation)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluNot:  result = ~opA;
            aluTcp:  result = '0 - opA;
            aluShl:  result = {opA[WordWidth-2:0], 1'b0};
            aluShr:  result = {opA[WordWidth-1], opA[WordWidth-1:1]}; // keeps the sign
            aluLhi:  result = {opB[ImmWidth-1:0], {(WordWidth - ImmWidth){1'b0}}};
            default: result = opA + opB;
        endcase
    end

    // branches run as A - B, with B = 0 for BGZ and BLZ
    assign isZero = (result == '0);
    assign isNegative = result[WordWidth-1];

    always_comb begin
        case (opcode)
            opBne:   branchTaken = !isZero;
            opBeq:   branchTaken = isZero;
            opBgz:   branchTaken = !isNegative && !isZero;
            opBlz:   branchTaken = isNegative;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import tscPkg::*; (
    input  opcodeE   opcode,
    input  funcCodeE funcCode,
    output pcSourceE pcSource,
    output aluSrcBE  aluSrcB,
    output aluOpE    aluOperation,
    output logic     isBranch,
    output logic     memRead,
    output logic     memWrite,
    output logic     outputActive,
    output logic     isHalt,
    output regDstE   regDst,
    output logic     regWrite,
    output memToRegE memToReg,
    output logic     zeroExtend
);

    logic isRtype;
    logic isRtypeArith;
    logic isRtypeSpecial;
    logic isRtypeJump;
    logic isItypeArith;
    logic isItypeMemory;
    logic isJtypeJump;
    logic isLink;

    // instruction groups
    assign isRtype = (opcode == opTypeR);
    assign isRtypeArith = isRtype && (funcCode inside {funcAdd, funcSub, funcAnd, funcOrr,
                                                       funcNot, funcTcp, funcShl, funcShr});
    assign isRtypeSpecial = isRtype && (funcCode inside {funcWwd, funcJpr, funcJrl});
    assign isRtypeJump = isRtype && (funcCode == funcJpr || funcCode == funcJrl);
    assign isItypeArith = (opcode inside {opAdi, opOri, opLhi});
    assign isItypeMemory = (opcode == opLwd) || (opcode == opSwd);
    assign isBranch = (opcode inside {opBne, opBeq, opBgz, opBlz});
    assign isJtypeJump = (opcode == opJmp) || (opcode == opJal);
    assign isLink = (opcode == opJal) || (isRtype && funcCode == funcJrl); // writes pc+1 to r2

    assign outputActive = isRtype && (funcCode == funcWwd);
    assign isHalt = isRtype && (funcCode == funcHlt);
    assign memRead = (opcode == opLwd);
    assign memWrite = (opcode == opSwd);
    assign zeroExtend = (opcode == opOri);

    always_comb begin
        aluOperation = aluAdd; // memory address and default
        if (isRtypeArith) begin
            case (funcCode)
                funcSub: aluOperation = aluSub;
                funcAnd: aluOperation = aluAnd;
                funcOrr: aluOperation = aluOr;
                funcNot: aluOperation = aluNot;
                funcTcp: aluOperation = aluTcp;
                funcShl: aluOperation = aluShl;
                funcShr: aluOperation = aluShr;
                default: aluOperation = aluAdd;
            endcase
        end else if (opcode == opOri) begin
            aluOperation = aluOr;
        end else if (opcode == opLhi) begin
            aluOperation = aluLhi;
        end else if (isBranch) begin
            aluOperation = aluSub; // branch test works on the difference
        end
    end

    always_comb begin
        if (opcode == opBgz || opcode == opBlz) begin
            aluSrcB = aluSrcBZero;
        end else if (isItypeArith || isItypeMemory) begin
            aluSrcB = aluSrcBImm;
        end else begin
            aluSrcB = aluSrcBReg; // R-type, BNE and BEQ compare two regs
        end
    end

    assign regDst = isLink ? regDst2 : (isRtype ? regDstRd : regDstRt);

    assign memToReg = isLink ? memToRegPc : (memRead ? memToRegMem : memToRegAlu);

    assign pcSource = isBranch ? pcBranch :
                      isJtypeJump ? pcJump :
                      isRtypeJump ? pcReg :
                      pcSeq;

    assign regWrite = isLink || isRtypeArith || isItypeArith || memRead;

    // R-type function codes outside the set decode to a no-op
    always_comb begin
        if (isRtype) begin
            assert (isRtypeArith || isRtypeSpecial || isHalt)
                else $error("undefined R-type function code %0d", funcCode);
        end
    end

endmodule

/* rtl/cpuSequencer.sv */
`timescale 1ns/1ps

module cpuSequencer import tscPkg::*; #(
    parameter logic [WordWidth-1:0] ResetPc = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  pcSourceE                pcSource,
    input  aluSrcBE                 aluSrcB,
    input  logic                    isBranch,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic                    outputActive,
    input  logic                    isHalt,
    input  regDstE                  regDst,
    input  logic                    regWrite,
    input  memToRegE                memToReg,
    input  logic                    zeroExtend,
    input  logic [WordWidth-1:0]    readData1,
    input  logic [WordWidth-1:0]    readData2,
    input  logic [WordWidth-1:0]    result,
    input  logic                    branchTaken,
    input  logic [WordWidth-1:0]    wbDatR,
    input  logic                    wbAck,
    output opcodeE                  opcode,
    output funcCodeE                funcCode,
    output logic [RegAddrWidth-1:0] readAddr1,
    output logic [RegAddrWidth-1:0] readAddr2,
    output logic [RegAddrWidth-1:0] writeAddr,
    output logic [WordWidth-1:0]    writeData,
    output logic                    writeEnable,
    output logic [WordWidth-1:0]    opB,
    output logic [WordWidth-1:0]    wbAdr,
    output logic [WordWidth-1:0]    wbDatW,
    output logic                    wbWe,
    output logic                    wbCyc,
    output logic                    wbStb,
    output logic [WordWidth-1:0]    outputPort,
    output logic                    outputValid,
    output logic                    halted
);

    typedef enum logic [2:0] {
        stFetch, stDecode, stExecute, stMemory, stWriteback, stHalted
    } cpuStateE;

    cpuStateE state;
    logic [WordWidth-1:0] pc;
    logic [WordWidth-1:0] ir;
    logic [WordWidth-1:0] aluOut;
    logic [WordWidth-1:0] mdr;
    logic takenReg;
    logic [WordWidth-1:0] pcPlus1;
    logic [WordWidth-1:0] immSext;
    logic [WordWidth-1:0] nextPc;
    logic [ImmWidth-1:0] imm;

    // instruction fields
    assign opcode = opcodeE'(ir[WordWidth-1 -: OpcodeWidth]);
    assign funcCode = funcCodeE'(ir[FuncWidth-1:0]);
    assign readAddr1 = ir[11:10]; // rs
    assign readAddr2 = ir[9:8];   // rt
    assign imm = ir[ImmWidth-1:0];
    assign immSext = {{(WordWidth - ImmWidth){imm[ImmWidth-1]}}, imm};

    always_comb begin
        case (aluSrcB)
            aluSrcBImm:  opB = zeroExtend ? {{(WordWidth - ImmWidth){1'b0}}, imm} : immSext;
            aluSrcBZero: opB = '0;
            default:     opB = readData2;
        endcase
    end

    assign pcPlus1 = pc + WordWidth'(1);

    always_comb begin
        nextPc = pcPlus1;
        case (pcSource)
            pcBranch: nextPc = takenReg ? pcPlus1 + immSext : pcPlus1;
            pcJump:   nextPc = {pc[WordWidth-1:TargetWidth], ir[TargetWidth-1:0]};
            pcReg:    nextPc = readData1;
            default:  nextPc = pcPlus1;
        endcase
    end

    // writeback
    always_comb begin
        case (regDst)
            regDstRd: writeAddr = ir[7:6];
            regDst2:  writeAddr = 2'd2;
            default:  writeAddr = ir[9:8];
        endcase
        case (memToReg)
            memToRegMem: writeData = mdr;
            memToRegPc:  writeData = pcPlus1;
            default:     writeData = aluOut;
        endcase
    end

    assign writeEnable = (state == stWriteback) && regWrite;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            pc <= ResetPc;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe <= 1'b0;
            outputValid <= 1'b0;
            halted <= 1'b0;
        end else begin
            outputValid <= 1'b0;
            case (state)
                stFetch: begin
                    if (!wbCyc) begin
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                        wbWe <= 1'b0;
                    end else if (wbAck) begin
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        state <= stDecode;
                    end
                end
                stDecode: state <= stExecute;
                stExecute: begin
                    outputValid <= outputActive; // high during writeback
                    if (isHalt) begin
                        halted <= 1'b1;
                    end
                    state <= (memRead || memWrite) ? stMemory : stWriteback;
                end
                stMemory: begin
                    if (!wbCyc) begin
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                        wbWe <= memWrite;
                    end else if (wbAck) begin
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        wbWe <= 1'b0;
                        state <= stWriteback;
                    end
                end
                stWriteback: begin
                    pc <= nextPc;
                    state <= halted ? stHalted : stFetch;
                end
                default: state <= stHalted; // stays until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            stFetch: begin
                if (!wbCyc) begin
                    wbAdr <= pc;
                end else if (wbAck) begin
                    ir <= wbDatR;
                end
            end
            stExecute: begin
                aluOut <= result;
                takenReg <= isBranch && branchTaken;
                if (outputActive) begin
                    outputPort <= readData1;
                end
            end
            stMemory: begin
                if (!wbCyc) begin
                    wbAdr <= aluOut;
                    wbDatW <= readData2;
                end else if (wbAck && memRead) begin
                    mdr <= wbDatR;
                end
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
        else $error("wbStb high without wbCyc");

    // a halted core neither writes registers nor starts bus cycles
    assert property (@(posedge clk) disable iff (reset) halted |-> !writeEnable && !wbCyc)
        else $error("activity while halted");

endmodule

/* rtl/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import tscPkg::*; #(
    parameter logic [WordWidth-1:0] ResetPc = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    output logic [WordWidth-1:0] wbAdr,
    output logic [WordWidth-1:0] wbDatW,
    input  logic [WordWidth-1:0] wbDatR,
    output logic                 wbWe,
    output logic                 wbCyc,
    output logic                 wbStb,
    input  logic                 wbAck,
    output logic [WordWidth-1:0] outputPort,
    output logic                 outputValid,
    output logic                 halted
);

    opcodeE opcode;
    funcCodeE funcCode;
    pcSourceE pcSource;
    aluSrcBE aluSrcB;
    aluOpE aluOperation;
    regDstE regDst;
    memToRegE memToReg;
    logic isBranch;
    logic memRead;
    logic memWrite;
    logic outputActive;
    logic isHalt;
    logic regWrite;
    logic zeroExtend;
    logic [RegAddrWidth-1:0] readAddr1;
    logic [RegAddrWidth-1:0] readAddr2;
    logic [RegAddrWidth-1:0] writeAddr;
    logic [WordWidth-1:0] writeData;
    logic writeEnable;
    logic [WordWidth-1:0] readData1;
    logic [WordWidth-1:0] readData2;
    logic [WordWidth-1:0] opB;
    logic [WordWidth-1:0] result;
    logic branchTaken;

    cpuSequencer #(.ResetPc(ResetPc)) sequencer (.*);

    controlUnit decoder (.*);

    registerFile regFile (.*);

    // operand A always comes from rs
    alu aluUnit (
        .aluOperation(aluOperation),
        .opA(readData1),
        .opB(opB),
        .opcode(opcode),
        .result(result),
        .branchTaken(branchTaken)
    );

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/1ps

module registerFile import tscPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [RegAddrWidth-1:0] readAddr1,
    input  logic [RegAddrWidth-1:0] readAddr2,
    input  logic [RegAddrWidth-1:0] writeAddr,
    input  logic [WordWidth-1:0]    writeData,
    input  logic                    writeEnable,
    output logic [WordWidth-1:0]    readData1,
    output logic [WordWidth-1:0]    readData2
);

    localparam int NumRegs = 2 ** RegAddrWidth;

    logic [WordWidth-1:0] regs [NumRegs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // reads are combinational
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

/* rtl/tscPkg.sv */
package tscPkg;

    // datapath and address width
    localparam int WordWidth = 16;

    // instruction fields
    localparam int OpcodeWidth = 4;
    localparam int RegAddrWidth = 2;
    localparam int FuncWidth = 6;
    localparam int ImmWidth = 8;
    localparam int TargetWidth = 12;

    typedef enum logic [OpcodeWidth-1:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opBgz   = 4'd2,
        opBlz   = 4'd3,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opJal   = 4'd10,
        opTypeR = 4'd15
    } opcodeE;

    // function codes, valid only with opTypeR
    typedef enum logic [FuncWidth-1:0] {
        funcAdd = 6'd0,
        funcSub = 6'd1,
        funcAnd = 6'd2,
        funcOrr = 6'd3,
        funcNot = 6'd4,
        funcTcp = 6'd5,
        funcShl = 6'd6,
        funcShr = 6'd7,
        funcJpr = 6'd25,
        funcJrl = 6'd26,
        funcWwd = 6'd28,
        funcHlt = 6'd29
    } funcCodeE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluNot, aluTcp, aluShl, aluShr, aluLhi
    } aluOpE;

    typedef enum logic [1:0] {pcSeq, pcBranch, pcJump, pcReg} pcSourceE;
    typedef enum logic [1:0] {regDstRt, regDstRd, regDst2} regDstE; // regDst2 is the link reg
    typedef enum logic [1:0] {memToRegAlu, memToRegMem, memToRegPc} memToRegE;
    typedef enum logic [1:0] {aluSrcBReg, aluSrcBImm, aluSrcBZero} aluSrcBE;

endpackage

/* run.sh */
#!/bin/sh
# builds the tbTop testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbTop -f sim.f -o tbSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1

/* sim.f */
rtl/tscPkg.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/cpuSequencer.sv
rtl/cpuTop.sv
verif/wbMemory.sv
verif/tbTop.sv

/* verif/tbTop.sv */
`timescale 1ns/1ps

module tbTop import tscPkg::*; ();

    localparam int MemWords = 256;
    localparam int HaltTimeout = 20000; // cycles
    localparam int MaxModelSteps = 5000;

    logic clk;
    logic reset;
    logic [WordWidth-1:0] wbAdr;
    logic [WordWidth-1:0] wbDatW;
    logic [WordWidth-1:0] wbDatR;
    logic wbWe;
    logic wbCyc;
    logic wbStb;
    logic wbAck;
    logic [WordWidth-1:0] outputPort;
    logic outputValid;
    logic halted;

    logic [15:0] prog [$];
    logic [15:0] modelMem [MemWords];
    logic [15:0] expQ [$]; // model WWD values in order
    integer seed;
    int pulseCount;
    int testErrors;
    int testsRun;
    int testsFailed;

    cpuTop #(.ResetPc(16'h0000)) dut (
        .clk(clk),
        .reset(reset),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbWe(wbWe),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAck(wbAck),
        .outputPort(outputPort),
        .outputValid(outputValid),
        .halted(halted)
    );

    wbMemory #(.Depth(MemWords), .ProtectedWords(128), .Seed(32'hb826_a6e6)) mem (
        .clk(clk),
        .reset(reset),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbWe(wbWe),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAck(wbAck)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int randomBelow(int n);
        logic [31:0] v;
        v = $random(seed);
        return int'(v % 32'(n));
    endfunction

    function automatic logic [15:0] randomWord();
        logic [31:0] v;
        v = $random(seed);
        return v[15:0];
    endfunction

    function automatic logic [1:0] randomReg();
        logic [31:0] v;
        v = $random(seed);
        return v[1:0];
    endfunction

    function automatic logic [15:0] encodeR(funcCodeE fn, logic [1:0] rs, logic [1:0] rt,
                                            logic [1:0] rd);
        return {opTypeR, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encodeI(opcodeE op, logic [1:0] rs, logic [1:0] rt,
                                            logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] encodeJ(opcodeE op, logic [11:0] target);
        return {op, target};
    endfunction

    // unused words get a pattern built from the address
    function automatic logic [15:0] fillWord(int a);
        logic [7:0] x;
        x = 8'(a);
        return {x ^ 8'h3c, x + 8'h71};
    endfunction

    task automatic emitLoad(logic [1:0] rd, logic [15:0] value);
        prog.push_back(encodeI(opLhi, 2'd0, rd, value[15:8]));
        prog.push_back(encodeI(opOri, rd, rd, value[7:0]));
    endtask

    task automatic emitWwd(logic [1:0] rs);
        prog.push_back(encodeR(funcWwd, rs, 2'd0, 2'd0));
    endtask

    task automatic emitWwdRun(int n);
        for (int i = 0; i < n; i++) begin
            emitWwd(randomReg());
        end
    endtask

    task automatic genArithmetic(int count);
        funcCodeE arithFuncs [8] = '{funcAdd, funcSub, funcAnd, funcOrr,
                                     funcNot, funcTcp, funcShl, funcShr};
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        opcodeE op;
        int kind;
        for (int i = 0; i < count; i++) begin
            rs = randomReg();
            rt = randomReg();
            rd = randomReg();
            kind = randomBelow(11);
            if (kind < 8) begin
                prog.push_back(encodeR(arithFuncs[kind], rs, rt, rd));
                emitWwd(rd);
            end else begin
                op = (kind == 8) ? opAdi : (kind == 9) ? opOri : opLhi;
                prog.push_back(encodeI(op, rs, rt, 8'(randomBelow(256))));
                emitWwd(rt);
            end
        end
    endtask

    task automatic genLoadStore(int count);
        logic [1:0] rb;
        logic [1:0] rv;
        logic [1:0] rd;
        logic [7:0] base;
        logic [7:0] imm;
        for (int i = 0; i < count; i++) begin
            rb = randomReg();
            rv = randomReg();
            rd = rb + 2'(1 + randomBelow(3)); // keeps the base intact
            base = 8'(randomBelow(256));
            imm = 8'(randomBelow(256));
            emitLoad(rb, {8'h00, base});
            prog.push_back(encodeI(opSwd, rb, rv, imm));
            prog.push_back(encodeI(opLwd, rb, rd, imm));
            emitWwd(rd);
        end
    endtask

    task automatic genBranches(int count);
        opcodeE op;
        logic [1:0] ra;
        logic [1:0] rb;
        logic [15:0] va;
        logic [15:0] vb;
        int skip;
        for (int i = 0; i < count; i++) begin
            case (i % 4)
                0: op = opBne;
                1: op = opBeq;
                2: op = opBgz;
                default: op = opBlz;
            endcase
            ra = randomReg();
            rb = ra + 2'(1 + randomBelow(3));
            va = randomWord();
            if (randomBelow(4) == 0) begin
                va = '0; // zero case for BGZ and BLZ
            end
            vb = (randomBelow(2) == 0) ? va : randomWord();
            emitLoad(ra, va);
            emitLoad(rb, vb);
            skip = 1 + randomBelow(3); // forward only
            prog.push_back(encodeI(op, ra, rb, 8'(skip)));
            emitWwdRun(skip);
            emitWwd(ra);
        end
    endtask

    task automatic genJumps();
        int at;
        emitWwd(2'd3);
        at = prog.size();
        prog.push_back(encodeJ(opJal, 12'(at + 3)));
        emitWwdRun(2);
        emitWwd(2'd2); // link from JAL
        at = prog.size();
        emitLoad(2'd1, 16'(at + 5));
        prog.push_back(encodeR(funcJpr, 2'd1, 2'd0, 2'd0));
        emitWwdRun(2);
        at = prog.size();
        emitLoad(2'd0, 16'(at + 4));
        prog.push_back(encodeR(funcJrl, 2'd0, 2'd0, 2'd0));
        emitWwdRun(1);
        emitWwd(2'd2); // link from JRL
        at = prog.size();
        prog.push_back(encodeJ(opJmp, 12'(at + 3)));
        emitWwdRun(2);
        emitWwd(2'd1);
        emitWwd(2'd0);
    endtask

    task automatic buildProgram(int testId);
        prog.delete();
        for (int r = 0; r < 4; r++) begin
            emitLoad(2'(r), randomWord());
        end
        case (testId)
            0: genArithmetic(12);
            1: genLoadStore(8);
            2: genBranches(8);
            3: genJumps();
            default: genArithmetic(6);
        endcase
        prog.push_back(encodeR(funcHlt, 2'd0, 2'd0, 2'd0));
        if (testId == 4) begin
            emitWwdRun(3); // never executed
        end
    endtask

    task automatic loadMemory();
        logic [15:0] w;
        for (int a = 0; a < MemWords; a++) begin
            if (a < prog.size()) begin
                w = prog[a];
            end else begin
                w = fillWord(a);
            end
            mem.words[a] = w;
            modelMem[a] = w;
        end
    endtask

    // instruction-level ISA interpreter
    task automatic runModel(output bit reachedHalt);
        logic [15:0] r [4];
        logic [15:0] pc;
        logic [15:0] nextPc;
        logic [15:0] ir;
        logic [15:0] sImm;
        logic [15:0] addr;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        int steps;
        reachedHalt = 1'b0;
        expQ.delete();
        for (int i = 0; i < 4; i++) begin
            r[i] = '0;
        end
        pc = 16'h0000;
        steps = 0;
        while (!reachedHalt && steps < MaxModelSteps) begin
            ir = modelMem[pc[7:0]];
            rs = ir[11:10];
            rt = ir[9:8];
            rd = ir[7:6];
            sImm = {{8{ir[7]}}, ir[7:0]};
            addr = r[rs] + sImm;
            nextPc = pc + 16'd1;
            case (ir[15:12])
                opTypeR: begin
                    case (ir[5:0])
                        funcAdd: r[rd] = r[rs] + r[rt];
                        funcSub: r[rd] = r[rs] - r[rt];
                        funcAnd: r[rd] = r[rs] & r[rt];
                        funcOrr: r[rd] = r[rs] | r[rt];
                        funcNot: r[rd] = ~r[rs];
                        funcTcp: r[rd] = 16'd0 - r[rs];
                        funcShl: r[rd] = r[rs] << 1;
                        funcShr: r[rd] = $signed(r[rs]) >>> 1;
                        funcWwd: expQ.push_back(r[rs]);
                        funcJpr: nextPc = r[rs];
                        funcJrl: begin
                            nextPc = r[rs]; // target read before the link write
                            r[2] = pc + 16'd1;
                        end
                        funcHlt: reachedHalt = 1'b1;
                        default: ;
                    endcase
                end
                opAdi: r[rt] = r[rs] + sImm;
                opOri: r[rt] = r[rs] | {8'h00, ir[7:0]};
                opLhi: r[rt] = {ir[7:0], 8'h00};
                opLwd: r[rt] = modelMem[addr[7:0]];
                opSwd: begin
                    if (addr[7]) begin // lower half ignores writes
                        modelMem[addr[7:0]] = r[rt];
                    end
                end
                opBne: if (r[rs] != r[rt]) nextPc = pc + 16'd1 + sImm;
                opBeq: if (r[rs] == r[rt]) nextPc = pc + 16'd1 + sImm;
                opBgz: if ($signed(r[rs]) > 16'sd0) nextPc = pc + 16'd1 + sImm;
                opBlz: if ($signed(r[rs]) < 16'sd0) nextPc = pc + 16'd1 + sImm;
                opJmp: nextPc = {pc[15:12], ir[11:0]};
                opJal: begin
                    r[2] = pc + 16'd1;
                    nextPc = {pc[15:12], ir[11:0]};
                end
                default: ;
            endcase
            pc = nextPc;
            steps++;
        end
    endtask

    task automatic checkOutput();
        assert (pulseCount < expQ.size()) else begin
            $display("error at %0t: WWD output number %0d is not in the model sequence",
                     $time, pulseCount + 1);
            testErrors++;
        end
        if (pulseCount < expQ.size()) begin
            assert (outputPort == expQ[pulseCount]) else begin
                $display("mismatch at %0t: outputPort got %h expected %h",
                         $time, outputPort, expQ[pulseCount]);
                testErrors++;
            end
        end
        pulseCount++;
    endtask

    task automatic checkHaltHolds();
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            assert (halted) else begin
                $display("mismatch at %0t: halted got 0 expected 1", $time);
                testErrors++;
            end
            assert (!wbCyc) else begin
                $display("mismatch at %0t: wbCyc got 1 expected 0", $time);
                testErrors++;
            end
        end
    endtask

    task automatic runTest(int testId, string name);
        bit modelHalted;
        int cycles;
        @(posedge clk);
        #1;
        reset = 1'b1;
        testErrors = 0;
        pulseCount = 0;
        buildProgram(testId);
        loadMemory();
        runModel(modelHalted);
        assert (modelHalted) else begin
            $display("error: model of test %0d never reached HLT", testId + 1);
            testErrors++;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        cycles = 0;
        while (!halted && cycles < HaltTimeout) begin
            @(posedge clk);
            #1;
            if (outputValid) begin
                checkOutput();
            end
            cycles++;
        end
        assert (halted) else begin
            $display("error at %0t: HLT not reached within %0d cycles", $time, HaltTimeout);
            testErrors++;
        end
        assert (pulseCount == expQ.size()) else begin
            $display("mismatch at %0t: outputValid pulse count got %0d expected %0d",
                     $time, pulseCount, expQ.size());
            testErrors++;
        end
        if (testId == 4) begin
            checkHaltHolds();
        end
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("test %0d (%s) %s: %0d outputs, %0d errors", testId + 1, name,
                 (testErrors == 0) ? "passed" : "failed", pulseCount, testErrors);
    endtask

    initial begin
        seed = 32'hb826_a6e6;
        reset = 1'b1;
        testsRun = 0;
        testsFailed = 0;
        runTest(0, "arithmetic");
        runTest(1, "loads and stores");
        runTest(2, "branches");
        runTest(3, "jumps and links");
        runTest(4, "halt and bus");
        $display("%0d tests run, %0d passed, %0d failed",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verif/wbMemory.sv */
`timescale 1ns/1ps

module wbMemory #(
    parameter int Depth = 256,
    parameter int ProtectedWords = 128, // writes below this index are dropped
    parameter logic [31:0] Seed = 32'h1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] wbAdr,
    input  logic [15:0] wbDatW,
    output logic [15:0] wbDatR,
    input  logic        wbWe,
    input  logic        wbCyc,
    input  logic        wbStb,
    output logic        wbAck
);

    localparam int AddrBits = $clog2(Depth);

    logic [15:0] words [Depth];
    logic [AddrBits-1:0] idx;
    logic busy;
    logic [31:0] draw;
    int waitLeft;
    integer seed;

    assign idx = wbAdr[AddrBits-1:0]; // upper address bits wrap

    initial begin
        seed = Seed;
        wbAck = 1'b0;
        wbDatR = '0;
        busy = 1'b0;
        waitLeft = 0;
        forever begin
            @(posedge clk);
            #1; // responses change just after the edge
            if (reset || wbAck) begin
                wbAck = 1'b0; // transfer ended on this edge
                busy = 1'b0;
            end else if (wbCyc && wbStb) begin
                if (!busy) begin
                    busy = 1'b1;
                    draw = $random(seed);
                    waitLeft = int'(draw % 4); // 0 to 3 wait cycles
                end
                if (waitLeft == 0) begin
                    wbAck = 1'b1;
                    if (!wbWe) begin
                        wbDatR = words[idx];
                    end else if (idx >= AddrBits'(ProtectedWords)) begin
                        words[idx] = wbDatW;
                    end
                end else begin
                    waitLeft--;
                end
            end
        end
    end

endmodule
